//--- common/rvCore_config.svh
`ifndef RVCORE_CONFIG_SVH
`define RVCORE_CONFIG_SVH

// core sizing
`define RV_XLEN       32            // data and address width
`define RV_NUM_REGS   32            // architectural registers incl x0

// memories, counted in 32-bit words
`define RV_IMEM_DEPTH 64            // program words, indexed by pc[7:2]
`define RV_DMEM_DEPTH 64            // data words

// fetch starts here after arstN is released
`define RV_RESET_PC   32'h0000_0000

`endif

//--- common/rvPkg.sv
package rvPkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,     // lw, lbu
        OP_IMM    = 7'b0010011,     // addi, slli
        OP_STORE  = 7'b0100011,     // sw, sb
        OP_REG    = 7'b0110011,     // add, sub
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,     // beq, bne
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111
    } opcodeT;

    typedef enum logic [1:0] {
        ALU_ADD   = 2'b00,
        ALU_SUB   = 2'b01,          // also the branch compare
        ALU_SLL   = 2'b10,
        ALU_PASSB = 2'b11           // lui just forwards the immediate
    } aluOpT;

    typedef enum logic [2:0] {
        IMM_I = 3'b000,
        IMM_S = 3'b001,
        IMM_B = 3'b010,
        IMM_J = 3'b011,
        IMM_U = 3'b100
    } immSrcT;

    typedef enum logic [1:0] {
        RES_ALU = 2'b00,
        RES_MEM = 2'b01,            // load data
        RES_PC4 = 2'b10             // link address for jal/jalr
    } resultSrcT;

    typedef struct packed {
        logic [6:0] funct7;         // bit 5 here is instr[30]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcodeT     opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm12;         // instr[31:20]
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcodeT      opcode;
    } iTypeT;

    typedef struct packed {
        logic [6:0] immHi;          // instr[31:25]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;          // instr[11:7]
        opcodeT     opcode;
    } sTypeT;

    // one fetched word, seen through whichever format the reader needs
    typedef union packed {
        rTypeT rType;
        iTypeT iType;
        sTypeT sType;
    } instrT;

endpackage

//--- design/controlUnit.sv
`timescale 1ns/100ps

module controlUnit (
    input  rvPkg::instrT     instr,
    input  logic             zero,       // alu result was zero
    output logic             regWrite,
    output rvPkg::immSrcT    immSrc,
    output logic             aluSrc,     // 1 = immediate into alu b
    output rvPkg::aluOpT     aluOp,
    output logic             memWrite,
    output logic             byteEn,     // sb, store low byte only
    output logic             loadByte,   // lbu, read path returns one byte
    output rvPkg::resultSrcT resultSrc,
    output logic             pcSrc,      // take the computed target
    output logic             jalrSel     // target from alu, not pc+imm
);

    rvPkg::opcodeT opcode;
    logic [2:0]    funct3;
    logic          funct7b30;

    assign opcode    = instr.rType.opcode;
    assign funct3    = instr.rType.funct3;
    assign funct7b30 = instr.rType.funct7[5];   // instr[30], add vs sub

    always_comb
    begin
        // everything idle unless the opcode says otherwise
        regWrite  = 1'b0;
        immSrc    = rvPkg::IMM_I;
        aluSrc    = 1'b0;
        aluOp     = rvPkg::ALU_ADD;
        memWrite  = 1'b0;
        byteEn    = 1'b0;
        loadByte  = 1'b0;
        resultSrc = rvPkg::RES_ALU;
        pcSrc     = 1'b0;
        jalrSel   = 1'b0;

        case (opcode)
            rvPkg::OP_IMM:
                case (funct3)
                    3'b000:                                     // addi
                    begin
                        regWrite = 1'b1;
                        aluSrc   = 1'b1;
                    end
                    3'b001:                                     // slli
                        if (!funct7b30)
                        begin
                            regWrite = 1'b1;
                            aluSrc   = 1'b1;
                            aluOp    = rvPkg::ALU_SLL;
                        end
                    default: ;
                endcase
            rvPkg::OP_REG:
                case (funct3)
                    3'b000:                                     // add / sub
                    begin
                        regWrite = 1'b1;
                        aluOp    = funct7b30 ? rvPkg::ALU_SUB : rvPkg::ALU_ADD;
                    end
                    default: ;
                endcase
            rvPkg::OP_LOAD:
                case (funct3)
                    3'b010,                                     // lw
                    3'b100:                                     // lbu
                    begin
                        regWrite  = 1'b1;
                        aluSrc    = 1'b1;
                        resultSrc = rvPkg::RES_MEM;
                        loadByte  = funct3[2];  // lbu
                    end
                    default: ;
                endcase
            rvPkg::OP_STORE:
                case (funct3)
                    3'b010,                                     // sw
                    3'b000:                                     // sb
                    begin
                        memWrite = 1'b1;
                        aluSrc   = 1'b1;
                        immSrc   = rvPkg::IMM_S;
                        byteEn   = (funct3 == 3'b000);
                    end
                    default: ;
                endcase
            rvPkg::OP_BRANCH:
                case (funct3)
                    3'b000,                                     // beq
                    3'b001:                                     // bne
                    begin
                        immSrc = rvPkg::IMM_B;
                        aluOp  = rvPkg::ALU_SUB;    // rs1 - rs2, look at zero
                        pcSrc  = funct3[0] ? !zero : zero;
                    end
                    default: ;
                endcase
            rvPkg::OP_JAL:
            begin
                regWrite  = 1'b1;
                immSrc    = rvPkg::IMM_J;
                resultSrc = rvPkg::RES_PC4;
                pcSrc     = 1'b1;
            end
            rvPkg::OP_JALR:
                if (funct3 == 3'b000)
                begin
                    regWrite  = 1'b1;
                    aluSrc    = 1'b1;                   // rs1 + imm on the alu
                    resultSrc = rvPkg::RES_PC4;
                    pcSrc     = 1'b1;
                    jalrSel   = 1'b1;
                end
            rvPkg::OP_LUI:
            begin
                regWrite = 1'b1;
                immSrc   = rvPkg::IMM_U;
                aluSrc   = 1'b1;
                aluOp    = rvPkg::ALU_PASSB;
            end
            default: ;                                  // retired as a no-op
        endcase
    end

endmodule

//--- design/alu.sv
`timescale 1ns/100ps

`include "rvCore_config.svh"

module alu (
    input  logic [`RV_XLEN-1:0] a,          // rs1
    input  logic [`RV_XLEN-1:0] b,          // rs2 or immediate
    input  rvPkg::aluOpT        aluOp,
    output logic [`RV_XLEN-1:0] result,
    output logic                zero        // feeds the branch decision
);

    always_comb
    begin
        case (aluOp)
            rvPkg::ALU_ADD:   result = a + b;
            rvPkg::ALU_SUB:   result = a - b;
            rvPkg::ALU_SLL:   result = a << b[4:0];   // shamt only
            rvPkg::ALU_PASSB: result = b;
            default:          result = a + b;
        endcase
    end

    assign zero = (result == '0);

endmodule

//--- design/regFile.sv
`timescale 1ns/100ps

`include "rvCore_config.svh"

module regFile (
    input  logic                clk,
    input  logic                arstN,
    input  logic [4:0]          rs1,
    input  logic [4:0]          rs2,
    input  logic [4:0]          rd,
    input  logic                we,
    input  logic [`RV_XLEN-1:0] wd,
    output logic [`RV_XLEN-1:0] rd1,
    output logic [`RV_XLEN-1:0] rd2
);

    logic [`RV_XLEN-1:0] regs [0:`RV_NUM_REGS-1];

    // whole array clears on reset, x0 is never written
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int i = 0; i < `RV_NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (we && (rd != 5'd0))
            regs[rd] <= wd;
    end

    // async read ports, x0 forced to zero
    assign rd1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

//--- design/immExtend.sv
`timescale 1ns/100ps

`include "rvCore_config.svh"

module immExtend (
    input  rvPkg::instrT        instr,
    input  rvPkg::immSrcT       immSrc,
    output logic [`RV_XLEN-1:0] imm
);

    always_comb
    begin
        case (immSrc)
            rvPkg::IMM_I:                               // addi, loads, jalr
                imm = {{(`RV_XLEN-12){instr.iType.imm12[11]}}, instr.iType.imm12};
            rvPkg::IMM_S:                               // split across hi/lo fields
                imm = {{(`RV_XLEN-12){instr.sType.immHi[6]}},
                       instr.sType.immHi, instr.sType.immLo};
            rvPkg::IMM_B:                               // same fields, reshuffled, bit 0 = 0
                imm = {{(`RV_XLEN-12){instr.sType.immHi[6]}},
                       instr.sType.immLo[0], instr.sType.immHi[5:0],
                       instr.sType.immLo[4:1], 1'b0};
            rvPkg::IMM_J:                               // imm[19:12] sits in rs1/funct3
                imm = {{(`RV_XLEN-20){instr.iType.imm12[11]}},
                       instr.iType.rs1, instr.iType.funct3,
                       instr.iType.imm12[0], instr.iType.imm12[10:1], 1'b0};
            rvPkg::IMM_U:                               // lui, upper 20 bits
                imm = {instr.iType.imm12, instr.iType.rs1, instr.iType.funct3, 12'b0};
            default:
                imm = '0;
        endcase
    end

endmodule

//--- design/dataMemory.sv
`timescale 1ns/100ps

`include "rvCore_config.svh"

module dataMemory (
    input  logic                clk,
    input  logic                arstN,
    input  logic [`RV_XLEN-1:0] addr,       // byte address from the alu
    input  logic [`RV_XLEN-1:0] wd,
    input  logic                we,
    input  logic                byteEn,     // sb
    input  logic                loadByte,   // lbu
    output logic [`RV_XLEN-1:0] rdata
);

    localparam int AW = $clog2(`RV_DMEM_DEPTH);   // word index bits

    logic [`RV_XLEN-1:0] mem [0:`RV_DMEM_DEPTH-1];
    logic [AW-1:0]       wordIdx;
    logic [4:0]          laneShift;              // bit offset of the addressed byte
    logic [`RV_XLEN-1:0] word;

    assign wordIdx   = addr[AW+1:2];
    assign laneShift = {addr[1:0], 3'b000};
    assign word      = mem[wordIdx];

    // writes blocked while in reset
    always_ff @(posedge clk)
    begin
        if (arstN && we)
        begin
            if (byteEn)
                mem[wordIdx][laneShift +: 8] <= wd[7:0];   // one lane only
            else
                mem[wordIdx] <= wd;
        end
    end

    // combinational read, lbu zero-extends the selected lane
    assign rdata = loadByte ? {{(`RV_XLEN-8){1'b0}}, word[laneShift +: 8]} : word;

    // word stores come from sw, which must be aligned
    assert property (@(posedge clk) disable iff (!arstN)
        (we && !byteEn) |-> (addr[1:0] == 2'b00))
        else $error("misaligned word store at %h", addr);

endmodule

//--- design/fetchUnit.sv
`timescale 1ns/100ps

`include "rvCore_config.svh"

module fetchUnit (
    input  logic                clk,
    input  logic                arstN,
    input  logic                progWe,     // program load port
    input  logic [5:0]          progAddr,
    input  logic [31:0]         progData,
    input  logic                pcSrc,
    input  logic                jalrSel,
    input  logic [`RV_XLEN-1:0] imm,
    input  logic [`RV_XLEN-1:0] aluResult,  // jalr target
    output logic [`RV_XLEN-1:0] pc,
    output logic [`RV_XLEN-1:0] pcPlus4,
    output rvPkg::instrT        instr
);

    logic [31:0]         imem [0:`RV_IMEM_DEPTH-1];
    logic [`RV_XLEN-1:0] pcTarget;
    logic [`RV_XLEN-1:0] pcNext;

    // program is written here from outside, no reset on the array
    always_ff @(posedge clk)
    begin
        if (progWe)
            imem[progAddr] <= progData;
    end

    assign instr = imem[pc[7:2]];    // word index

    assign pcPlus4  = pc + `RV_XLEN'(4);
    // branch and jal go pc-relative, jalr drops bit 0 of rs1+imm
    assign pcTarget = jalrSel ? {aluResult[`RV_XLEN-1:1], 1'b0} : pc + imm;
    assign pcNext   = pcSrc ? pcTarget : pcPlus4;

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
            pc <= `RV_RESET_PC;
        else
            pc <= pcNext;
    end

    // the outside only loads code while the core is held in reset
    assert property (@(posedge clk) arstN |-> !progWe)
        else $error("program write while core running");

endmodule

//--- design/rvCore.sv
`timescale 1ns/100ps

`include "rvCore_config.svh"

module rvCore (
    input  logic                clk,
    input  logic                arstN,
    input  logic                progWe,
    input  logic [5:0]          progAddr,
    input  logic [31:0]         progData,
    output logic [`RV_XLEN-1:0] pc,
    output logic                commitRegWe,
    output logic [4:0]          commitRd,
    output logic [`RV_XLEN-1:0] commitData,
    output logic                commitMemWe,
    output logic [`RV_XLEN-1:0] commitAddr,
    output logic [`RV_XLEN-1:0] commitStoreData
);

    rvPkg::instrT        instr;
    logic [`RV_XLEN-1:0] pcPlus4;
    logic                regWrite;
    rvPkg::immSrcT       immSrc;
    logic                aluSrc;
    rvPkg::aluOpT        aluOp;
    logic                memWrite;
    logic                byteEn;
    logic                loadByte;
    rvPkg::resultSrcT    resultSrc;
    logic                pcSrc;
    logic                jalrSel;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] rs1Data;
    logic [`RV_XLEN-1:0] rs2Data;
    logic [`RV_XLEN-1:0] aluB;
    logic [`RV_XLEN-1:0] aluResult;
    logic                zero;
    logic [`RV_XLEN-1:0] readData;
    logic [`RV_XLEN-1:0] result;        // writeback value

    fetchUnit fetchUnit_i (
        .clk(clk), .arstN(arstN),
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .pcSrc(pcSrc), .jalrSel(jalrSel), .imm(imm), .aluResult(aluResult),
        .pc(pc), .pcPlus4(pcPlus4), .instr(instr)
    );

    controlUnit controlUnit_i (
        .instr(instr), .zero(zero),
        .regWrite(regWrite), .immSrc(immSrc), .aluSrc(aluSrc), .aluOp(aluOp),
        .memWrite(memWrite), .byteEn(byteEn), .loadByte(loadByte),
        .resultSrc(resultSrc), .pcSrc(pcSrc), .jalrSel(jalrSel)
    );

    immExtend immExtend_i (.instr(instr), .immSrc(immSrc), .imm(imm));

    // register indices come straight from the r-type view
    regFile regFile_i (
        .clk(clk), .arstN(arstN),
        .rs1(instr.rType.rs1), .rs2(instr.rType.rs2), .rd(instr.rType.rd),
        .we(regWrite), .wd(result),
        .rd1(rs1Data), .rd2(rs2Data)
    );

    assign aluB = aluSrc ? imm : rs2Data;   // operand mux

    alu alu_i (.a(rs1Data), .b(aluB), .aluOp(aluOp), .result(aluResult), .zero(zero));

    dataMemory dataMemory_i (
        .clk(clk), .arstN(arstN),
        .addr(aluResult), .wd(rs2Data), .we(memWrite),
        .byteEn(byteEn), .loadByte(loadByte), .rdata(readData)
    );

    always_comb
    begin
        case (resultSrc)
            rvPkg::RES_MEM: result = readData;
            rvPkg::RES_PC4: result = pcPlus4;   // link
            default:        result = aluResult;
        endcase
    end

    // what the instruction at pc commits this cycle
    assign commitRegWe     = regWrite;
    assign commitRd        = instr.rType.rd;
    assign commitData      = result;
    assign commitMemWe     = memWrite;
    assign commitAddr      = aluResult;
    assign commitStoreData = rs2Data;

endmodule

//--- verification/rvCoreChecker.sv
`timescale 1ns/100ps

`include "rvCore_config.svh"

module rvCoreChecker (
    input  logic                clk,
    input  logic                arstN,
    input  logic [`RV_XLEN-1:0] pc,
    input  logic                commitRegWe,
    input  logic [4:0]          commitRd,
    input  logic [`RV_XLEN-1:0] commitData,
    input  logic                commitMemWe,
    input  logic [`RV_XLEN-1:0] commitAddr,
    input  logic [`RV_XLEN-1:0] commitStoreData,
    input  logic                expRegWe [`RV_IMEM_DEPTH],   // one row per program word
    input  logic [4:0]          expRd [`RV_IMEM_DEPTH],
    input  logic [`RV_XLEN-1:0] expData [`RV_IMEM_DEPTH],
    input  logic                expMemWe [`RV_IMEM_DEPTH],
    input  logic [`RV_XLEN-1:0] expAddr [`RV_IMEM_DEPTH],
    input  logic [`RV_XLEN-1:0] expStore [`RV_IMEM_DEPTH],
    input  logic [`RV_XLEN-1:0] expNext [`RV_IMEM_DEPTH],
    output int                  errCount
);

    int                  errs = 0;
    int                  row;                // table row of the current pc
    logic [`RV_XLEN-1:0] nextPc;             // target left by the previous instruction

    assign errCount = errs;

    task automatic compare(input string name, input logic [`RV_XLEN-1:0] got,
                           input logic [`RV_XLEN-1:0] want);
        if (got !== want)
        begin
            $display("Mismatch %s at pc %h: got %h, expected %h", name, pc, got, want);
            errs++;
        end
    endtask

    // sampled on the edge that retires the instruction
    always @(posedge clk)
    begin
        if (!arstN)
            nextPc = `RV_RESET_PC;           // commit ports undefined here
        else
        begin
            row = int'(pc[7:2]);
            compare("pc", pc, nextPc);
            compare("commitRegWe", {31'b0, commitRegWe}, {31'b0, expRegWe[row]});
            if (expRegWe[row])               // rd and data only mean something on a write
            begin
                compare("commitRd", {27'b0, commitRd}, {27'b0, expRd[row]});
                compare("commitData", commitData, expData[row]);
            end
            compare("commitMemWe", {31'b0, commitMemWe}, {31'b0, expMemWe[row]});
            if (expMemWe[row])
            begin
                compare("commitAddr", commitAddr, expAddr[row]);
                compare("commitStoreData", commitStoreData, expStore[row]);
            end
            nextPc = expNext[row];
        end
    end

endmodule

//--- verification/rvCoreTb.sv
`timescale 1ns/100ps

`include "rvCore_config.svh"

module rvCoreTb;

    localparam int          depth       = `RV_IMEM_DEPTH;
    localparam logic [31:0] endPc       = 32'd124;   // marker word, a no-op
    localparam int          stepTimeout = 8;         // cycles allowed for one pc move
    localparam int          maxSteps    = 64;
    localparam int          opImm       = 'h13;
    localparam int          opLoad      = 'h03;
    localparam int          opJalr      = 'h67;

    logic        clk = 1'b0;
    logic        arstN;
    logic        progWe;
    logic [5:0]  progAddr;
    logic [31:0] progData;
    logic [31:0] pc;
    logic        commitRegWe;
    logic [4:0]  commitRd;
    logic [31:0] commitData;
    logic        commitMemWe;
    logic [31:0] commitAddr;
    logic [31:0] commitStoreData;

    logic [31:0] instrTab [depth];
    logic        expRegWe [depth];
    logic [4:0]  expRd [depth];
    logic [31:0] expData [depth];
    logic        expMemWe [depth];
    logic [31:0] expAddr [depth];
    logic [31:0] expStore [depth];
    logic [31:0] expNext [depth];
    int          nRows;
    int          steps;
    int          timeouts;
    int          errCount;
    int          i1, i2, sh, u;                      // random immediates
    logic [31:0] x1, x2, x3, x4, x5, x6;              // expected register contents

    always #20 clk = ~clk;

    rvCore dut_i (
        .clk(clk), .arstN(arstN),
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .pc(pc), .commitRegWe(commitRegWe), .commitRd(commitRd), .commitData(commitData),
        .commitMemWe(commitMemWe), .commitAddr(commitAddr), .commitStoreData(commitStoreData)
    );

    rvCoreChecker checker_i (
        .clk(clk), .arstN(arstN), .pc(pc),
        .commitRegWe(commitRegWe), .commitRd(commitRd), .commitData(commitData),
        .commitMemWe(commitMemWe), .commitAddr(commitAddr), .commitStoreData(commitStoreData),
        .expRegWe(expRegWe), .expRd(expRd), .expData(expData), .expMemWe(expMemWe),
        .expAddr(expAddr), .expStore(expStore), .expNext(expNext), .errCount(errCount)
    );

    function automatic logic [31:0] sext12(input int v);
        return {{20{v[11]}}, v[11:0]};
    endfunction

    function automatic logic [31:0] iEnc(input int imm, rs1, f3, rd, op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] rEnc(input int f7, rs2, rs1, rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'h33};   // add / sub
    endfunction

    function automatic logic [31:0] sEnc(input int imm, rs2, rs1, f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] bEnc(input int imm, rs2, rs1, f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] jEnc(input int imm, rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    // one table row at pc = 4 * nRows
    task automatic addRow(input logic [31:0] word, input int we, rd, input logic [31:0] data,
                          input int memWe, input logic [31:0] addr, store, next);
        instrTab[nRows] = word;
        expRegWe[nRows] = we[0];
        expRd[nRows]    = rd[4:0];
        expData[nRows]  = data;
        expMemWe[nRows] = memWe[0];
        expAddr[nRows]  = addr;
        expStore[nRows] = store;
        expNext[nRows]  = next;
        nRows++;
    endtask

    task automatic buildProgram();
        i1 = int'(($urandom() & 32'hfff) | 32'h080);   // low byte >= 0x80 for lbu
        i2 = int'(($urandom() & 32'hfff) | 32'h001);   // nonzero, so x1 != x2
        sh = int'($urandom() & 32'h1f);
        u  = int'($urandom() & 32'hfffff);
        x1 = sext12(i1);
        x2 = x1 + sext12(i2);
        x3 = x1 + x2;
        x4 = x1 - x2;
        x5 = x2 << sh;
        x6 = {u[19:0], 12'h000};
        nRows = 0;
        addRow(iEnc(i1, 0, 0, 1, opImm), 1, 1, x1, 0, 0, 0, 4);           // addi x1
        addRow(iEnc(i2, 1, 0, 2, opImm), 1, 2, x2, 0, 0, 0, 8);
        addRow(rEnc(0, 2, 1, 3), 1, 3, x3, 0, 0, 0, 12);                  // add
        addRow(rEnc('h20, 2, 1, 4), 1, 4, x4, 0, 0, 0, 16);               // sub
        addRow(iEnc(sh, 2, 1, 5, opImm), 1, 5, x5, 0, 0, 0, 20);          // slli
        addRow({u[19:0], 5'd6, 7'h37}, 1, 6, x6, 0, 0, 0, 24);            // lui
        addRow(iEnc(64, 0, 0, 7, opImm), 1, 7, 64, 0, 0, 0, 28);          // x7 = data base
        addRow(sEnc(0, 6, 7, 2), 0, 0, 0, 1, 64, x6, 32);                 // sw
        addRow(iEnc(0, 7, 2, 8, opLoad), 1, 8, x6, 0, 0, 0, 36);          // lw
        addRow(sEnc(4, 1, 7, 0), 0, 0, 0, 1, 68, x1, 40);                 // sb, lanes 0..3
        addRow(sEnc(5, 2, 7, 0), 0, 0, 0, 1, 69, x2, 44);
        addRow(sEnc(6, 3, 7, 0), 0, 0, 0, 1, 70, x3, 48);
        addRow(sEnc(7, 4, 7, 0), 0, 0, 0, 1, 71, x4, 52);
        addRow(iEnc(4, 7, 4, 9, opLoad), 1, 9, {24'h0, x1[7:0]}, 0, 0, 0, 56);   // lbu
        addRow(iEnc(5, 7, 4, 10, opLoad), 1, 10, {24'h0, x2[7:0]}, 0, 0, 0, 60);
        addRow(iEnc(6, 7, 4, 11, opLoad), 1, 11, {24'h0, x3[7:0]}, 0, 0, 0, 64);
        addRow(iEnc(7, 7, 4, 12, opLoad), 1, 12, {24'h0, x4[7:0]}, 0, 0, 0, 68);
        addRow(bEnc(8, 9, 9, 0), 0, 0, 0, 0, 0, 0, 76);                   // beq taken
        addRow(iEnc(1, 0, 0, 13, opImm), 1, 13, 1, 0, 0, 0, 76);          // skipped
        addRow(bEnc(8, 2, 1, 0), 0, 0, 0, 0, 0, 0, 80);                   // beq falls through
        addRow(bEnc(8, 2, 1, 1), 0, 0, 0, 0, 0, 0, 88);                   // bne taken
        addRow(iEnc(1, 0, 0, 13, opImm), 1, 13, 1, 0, 0, 0, 88);          // skipped
        addRow(bEnc(8, 9, 9, 1), 0, 0, 0, 0, 0, 0, 92);                   // bne falls through
        addRow(jEnc(8, 13), 1, 13, 96, 0, 0, 0, 100);                     // jal
        addRow(iEnc(1, 0, 0, 13, opImm), 1, 13, 1, 0, 0, 0, 100);         // skipped
        addRow(iEnc(49, 7, 0, 14, opJalr), 1, 14, 104, 0, 0, 0, 112);     // 64+49, bit 0 off
        addRow(iEnc(1, 0, 0, 13, opImm), 1, 13, 1, 0, 0, 0, 108);         // skipped
        addRow(iEnc(1, 0, 0, 13, opImm), 1, 13, 1, 0, 0, 0, 112);         // skipped
        addRow(iEnc(5, 1, 0, 0, opImm), 1, 0, x1 + 32'd5, 0, 0, 0, 116);  // write to x0
        addRow(rEnc(0, 0, 0, 15), 1, 15, 0, 0, 0, 0, 120);                // x0 + x0
        addRow(iEnc('h123, 1, 0, 16, 'h0b), 0, 0, 0, 0, 0, 0, 124);       // custom-0, no-op
        addRow(32'h0, 0, 0, 0, 0, 0, 0, 128);                             // end marker
    endtask

    // wait for the pc to leave a value, bounded
    task automatic waitPcMove(input logic [31:0] from);
        int n;
        n = 0;
        while (pc == from && n < stepTimeout)
        begin
            @(negedge clk);
            n++;
        end
        if (pc == from)
        begin
            $display("Timeout: pc stayed at %h for %0d cycles", from, stepTimeout);
            timeouts++;
        end
    endtask

    initial
    begin
        arstN    = 1'b0;
        progWe   = 1'b0;
        progAddr = '0;
        progData = '0;
        timeouts = 0;
        steps    = 0;
        void'($urandom(73499));
        buildProgram();
        @(negedge clk);
        for (int r = 0; r < nRows; r++)                  // code goes in under reset
        begin
            progWe   = 1'b1;
            progAddr = r[5:0];
            progData = instrTab[r];
            @(negedge clk);
        end
        progWe = 1'b0;
        repeat (5) @(negedge clk);                       // reset cycles
        arstN = 1'b1;
        while (pc != endPc && steps < maxSteps && timeouts == 0)
        begin
            waitPcMove(pc);
            steps++;
        end
        if (pc != endPc && timeouts == 0)
        begin
            $display("Timeout: pc did not reach the end marker within %0d steps", maxSteps);
            timeouts++;
        end
        @(negedge clk);                                  // checker sees the marker row
        $display("Errors: %0d mismatches, %0d timeouts", errCount, timeouts);
        if (errCount == 0 && timeouts == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

//--- rvCore.f
+incdir+common
common/rvPkg.sv
design/controlUnit.sv
design/alu.sv
design/regFile.sv
design/immExtend.sv
design/dataMemory.sv
design/fetchUnit.sv
design/rvCore.sv
verification/rvCoreChecker.sv
verification/rvCoreTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module rvCoreTb -f rvCore.f -o rvCoreSim \
    && ./obj_dir/rvCoreSim | tee /dev/stderr | grep -q "Verification passed" \
    && echo "run.sh: PASS" \
    || { echo "run.sh: FAIL"; exit 1; }
